/* Makefile */
# Verilator build and run for the ALU testbench

SRCS := $(wildcard design/*.sv design/*.svh bench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Valu_tb: alu_top.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f alu_top.f --top-module alu_tb -o Valu_tb

sim.log: obj_dir/Valu_tb
	./obj_dir/Valu_tb > sim.log 2>&1 || true

run: sim.log
	cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* alu_top.f */
+incdir+design
design/alu_pkg.sv
design/arith_unit.sv
design/logic_shift_unit.sv
design/result_select.sv
design/alu_top.sv
bench/clock_gen.sv
bench/alu_tb.sv

/* bench/alu_tb.sv */
`timescale 1ns/1ns
`include "alu_macros.svh"

module alu_tb;

  import alu_pkg::*;

  localparam int N_RANDOM     = 200;
  localparam int RESET_CYCLES = 4;

  typedef struct {
    logic    z_in;
    logic    inc_pc;
    opcode_t opcode;
    word_t   a;
    word_t   b;
    word_t   hi;
    word_t   lo;
  } vec_t;

  logic    clock;
  logic    rst_n;
  logic    z_in;
  logic    inc_pc;
  opcode_t opcode;
  word_t   a_reg;
  word_t   b_reg;
  word_t   z_hi;
  word_t   z_lo;

  vec_t tbl[$];
  logic table_built = 1'b0;
  int   err_count   = 0;
  int   pass_count  = 0;
  int   fail_count  = 0;

  clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(RESET_CYCLES)) clock_gen_inst (
    .clock (clock),
    .rst_n (rst_n)
  );

  alu_top alu_top_inst (
    .clock  (clock),
    .rst_n  (rst_n),
    .z_in   (z_in),
    .inc_pc (inc_pc),
    .opcode (opcode),
    .a_reg  (a_reg),
    .b_reg  (b_reg),
    .z_hi   (z_hi),
    .z_lo   (z_lo)
  );

  function automatic word_t lcg_next(input word_t s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Expected Z after a load, straight from the opcode rules
  function automatic dword_t ref_result(input logic inc, input opcode_t op,
                                        input word_t a, input word_t b, input dword_t prev);
    shamt_t sh;

    sh = b[`ALU_SHAMT_W-1:0];
    if (inc) return {32'h0, a + 32'd1};
    case (op)
      `ALU_OP_ADD:  return {32'h0, a + b};
      `ALU_OP_SUB:  return {32'h0, a - b};
      `ALU_OP_NEG:  return {32'h0, 32'h0 - b};
      `ALU_OP_MUL:  return longint'($signed(a)) * longint'($signed(b));
      `ALU_OP_DIV: begin
        if (b == 32'h0) return {a, 32'hffff_ffff};
        if (b == 32'hffff_ffff) return {32'h0, 32'h0 - a};  // Avoids signed overflow
        return {word_t'($signed(a) % $signed(b)), word_t'($signed(a) / $signed(b))};
      end
      `ALU_OP_AND:  return {32'h0, a & b};
      `ALU_OP_OR:   return {32'h0, a | b};
      `ALU_OP_NOT:  return {32'h0, ~b};
      `ALU_OP_SHR:  return {32'h0, a >> sh};
      `ALU_OP_SHRA: return {32'h0, word_t'($signed(a) >>> sh)};
      `ALU_OP_SHL:  return {32'h0, a << sh};
      `ALU_OP_ROR:  return {32'h0, (a >> sh) | (a << (6'd32 - sh))};
      `ALU_OP_ROL:  return {32'h0, (a << sh) | (a >> (6'd32 - sh))};
      `ALU_OP_NOP:  return prev;
      default:      return 64'h0;
    endcase
  endfunction

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
      err_count++;
    end
  endtask

  task automatic report_test(input string label, input int errs_before);
    if (err_count == errs_before) begin
      pass_count++;
      $display("test %-22s ok", label);
    end else begin
      fail_count++;
      $display("test %-22s failed, %0d wrong values", label, err_count - errs_before);
    end
  endtask

  task automatic drive_inputs(input logic z, input logic inc, input opcode_t op,
                              input word_t a, input word_t b);
    z_in   = z;
    inc_pc = inc;
    opcode = op;
    a_reg  = a;
    b_reg  = b;
  endtask

  task automatic add_entry(input int z, input int inc, input opcode_t op, input word_t a,
                           input word_t b, input word_t hi, input word_t lo);
    vec_t v;

    v.z_in   = (z != 0);
    v.inc_pc = (inc != 0);
    v.opcode = op;
    v.a      = a;
    v.b      = b;
    v.hi     = hi;
    v.lo     = lo;
    tbl.push_back(v);
  endtask

  task automatic build_table();
    add_entry(1, 0, `ALU_OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 32'h0, 32'h8000_0000);
    add_entry(1, 0, `ALU_OP_ADD, 32'hffff_ffff, 32'h0000_0002, 32'h0, 32'h0000_0001);
    add_entry(1, 0, `ALU_OP_SUB, 32'h0000_0005, 32'h0000_0007, 32'h0, 32'hffff_fffe);
    add_entry(1, 0, `ALU_OP_SUB, 32'h8000_0000, 32'h0000_0001, 32'h0, 32'h7fff_ffff);
    add_entry(1, 0, `ALU_OP_AND, 32'hf0f0_1234, 32'h0ff0_ff00, 32'h0, 32'h00f0_1200);
    add_entry(1, 0, `ALU_OP_OR, 32'hf0f0_0000, 32'h0f0f_1234, 32'h0, 32'hffff_1234);
    add_entry(1, 0, `ALU_OP_NOT, 32'hdead_beef, 32'h1234_5678, 32'h0, 32'hedcb_a987);
    add_entry(1, 0, `ALU_OP_NEG, 32'h0000_0000, 32'h0000_0005, 32'h0, 32'hffff_fffb);
    add_entry(1, 0, `ALU_OP_NEG, 32'h1111_1111, 32'h8000_0000, 32'h0, 32'h8000_0000);
    add_entry(1, 0, `ALU_OP_SHR, 32'h8000_0001, 32'hffff_ffe4, 32'h0, 32'h0800_0000);
    add_entry(1, 0, `ALU_OP_SHR, 32'h8000_0000, 32'hffff_ffff, 32'h0, 32'h0000_0001);
    add_entry(1, 0, `ALU_OP_SHRA, 32'h8000_0000, 32'hffff_ffff, 32'h0, 32'hffff_ffff);
    add_entry(1, 0, `ALU_OP_SHRA, 32'h8765_4321, 32'hffff_ffe0, 32'h0, 32'h8765_4321);
    add_entry(1, 0, `ALU_OP_SHRA, 32'h4000_0000, 32'h0000_0022, 32'h0, 32'h1000_0000);
    add_entry(1, 0, `ALU_OP_SHL, 32'h0000_0001, 32'hffff_ffff, 32'h0, 32'h8000_0000);
    add_entry(1, 0, `ALU_OP_SHL, 32'h1234_5678, 32'h0000_0024, 32'h0, 32'h2345_6780);
    add_entry(1, 0, `ALU_OP_ROR, 32'h1234_5678, 32'hffff_ffe8, 32'h0, 32'h7812_3456);
    add_entry(1, 0, `ALU_OP_ROR, 32'h8000_0001, 32'h0000_0000, 32'h0, 32'h8000_0001);
    add_entry(1, 0, `ALU_OP_ROL, 32'h8000_0001, 32'hffff_ffff, 32'h0, 32'hc000_0000);
    add_entry(1, 0, `ALU_OP_ROL, 32'h1234_5678, 32'h0000_0004, 32'h0, 32'h2345_6781);
    add_entry(1, 0, `ALU_OP_MUL, 32'hffff_fffd, 32'h0000_0007, 32'hffff_ffff, 32'hffff_ffeb);
    add_entry(1, 0, `ALU_OP_MUL, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000, 32'h0);
    add_entry(1, 0, `ALU_OP_MUL, 32'h8000_0000, 32'h7fff_ffff, 32'hc000_0000, 32'h8000_0000);
    add_entry(1, 0, `ALU_OP_MUL, 32'h7fff_ffff, 32'h7fff_ffff, 32'h3fff_ffff, 32'h0000_0001);
    add_entry(1, 0, `ALU_OP_MUL, 32'h1234_5678, 32'h0000_0000, 32'h0, 32'h0);
    add_entry(1, 0, `ALU_OP_DIV, 32'hffff_fff9, 32'h0000_0002, 32'hffff_ffff, 32'hffff_fffd);
    add_entry(1, 0, `ALU_OP_DIV, 32'h0000_0007, 32'hffff_fffe, 32'h0000_0001, 32'hffff_fffd);
    add_entry(1, 0, `ALU_OP_DIV, 32'hffff_fff9, 32'hffff_fffe, 32'hffff_ffff, 32'h0000_0003);
    add_entry(1, 0, `ALU_OP_DIV, 32'h0000_0064, 32'h0000_0007, 32'h0000_0002, 32'h0000_000e);
    add_entry(1, 0, `ALU_OP_DIV, 32'h8000_0000, 32'hffff_ffff, 32'h0, 32'h8000_0000);
    add_entry(1, 0, `ALU_OP_DIV, 32'h1234_5678, 32'h0000_0000, 32'h1234_5678, 32'hffff_ffff);
    add_entry(1, 0, `ALU_OP_DIV, 32'hffff_fff9, 32'h0000_0000, 32'hffff_fff9, 32'hffff_ffff);
    add_entry(1, 1, `ALU_OP_AND, 32'h0000_0fff, 32'h0000_0000, 32'h0, 32'h0000_1000);
    add_entry(1, 1, `ALU_OP_MUL, 32'hffff_ffff, 32'hffff_ffff, 32'h0, 32'h0);
    add_entry(1, 1, `ALU_OP_NOP, 32'h0000_0100, 32'h5555_5555, 32'h0, 32'h0000_0101);
    add_entry(1, 0, `ALU_OP_ADD, 32'h0000_0010, 32'h0000_0020, 32'h0, 32'h0000_0030);
    add_entry(1, 0, `ALU_OP_NOP, 32'hcafe_f00d, 32'h0bad_cafe, 32'h0, 32'h0000_0030);
    add_entry(0, 0, `ALU_OP_DIV, 32'h0000_0009, 32'h0000_0000, 32'h0, 32'h0000_0030);
    add_entry(0, 1, `ALU_OP_ADD, 32'h7777_7777, 32'h0000_0001, 32'h0, 32'h0000_0030);
    add_entry(1, 0, 5'b00000, 32'h1234_5678, 32'h8765_4321, 32'h0, 32'h0);
    add_entry(1, 0, `ALU_OP_MUL, 32'hffff_ffff, 32'h0000_0002, 32'hffff_ffff, 32'hffff_fffe);
    add_entry(1, 0, `ALU_OP_NOP, 32'h0000_0000, 32'h0000_0000, 32'hffff_ffff, 32'hffff_fffe);
    add_entry(1, 0, 5'b11111, 32'hffff_ffff, 32'hffff_ffff, 32'h0, 32'h0);
  endtask

  initial begin : main
    int      errs_before;
    word_t   seed;
    word_t   a;
    word_t   b;
    word_t   ctrl;
    logic    z;
    logic    inc;
    opcode_t op;
    dword_t  exp_z;
    opcode_t valid_ops [14];

    drive_inputs(1'b0, 1'b0, '0, '0, '0);
    valid_ops = '{`ALU_OP_ADD, `ALU_OP_SUB, `ALU_OP_SHR, `ALU_OP_SHRA, `ALU_OP_SHL,
                  `ALU_OP_ROR, `ALU_OP_ROL, `ALU_OP_AND, `ALU_OP_OR, `ALU_OP_MUL,
                  `ALU_OP_DIV, `ALU_OP_NEG, `ALU_OP_NOT, `ALU_OP_NOP};
    build_table();
    table_built = 1'b1;

    wait (rst_n === 1'b1);
    errs_before = err_count;
    check_value("z_hi", 32'h0, z_hi);
    check_value("z_lo", 32'h0, z_lo);
    report_test("reset", errs_before);

    foreach (tbl[i]) begin
      errs_before = err_count;
      drive_inputs(tbl[i].z_in, tbl[i].inc_pc, tbl[i].opcode, tbl[i].a, tbl[i].b);
      @(posedge clock);
      #1;
      check_value("z_hi", tbl[i].hi, z_hi);
      check_value("z_lo", tbl[i].lo, z_lo);
      report_test($sformatf("entry %0d op %b", i, tbl[i].opcode), errs_before);
    end

    // Model Z continues from the last table entry
    exp_z       = {tbl[tbl.size()-1].hi, tbl[tbl.size()-1].lo};
    seed        = 32'hc941_52df;
    errs_before = err_count;
    for (int n = 0; n < N_RANDOM; n++) begin
      seed = lcg_next(seed);
      a    = seed;
      seed = lcg_next(seed);
      b    = seed;
      seed = lcg_next(seed);
      ctrl = seed;
      inc  = (ctrl[31:28] == 4'h0);
      z    = (ctrl[27:25] != 3'h0);
      if (ctrl[24:21] == 4'h0) b = 32'h0;  // Some divides by zero
      if (ctrl[20:19] == 2'b00) begin
        op = ctrl[18:14];  // Raw code, may be undefined
      end else begin
        op = valid_ops[ctrl[18:14] % 14];
      end
      drive_inputs(z, inc, op, a, b);
      if (z) exp_z = ref_result(inc, op, a, b, exp_z);
      @(posedge clock);
      #1;
      check_value("z_hi", exp_z[63:32], z_hi);
      check_value("z_lo", exp_z[31:0], z_lo);
    end
    report_test($sformatf("random x%0d", N_RANDOM), errs_before);

    $display("tests passed %0d, tests failed %0d, wrong values %0d",
             pass_count, fail_count, err_count);
    if (err_count == 0 && fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int limit_ns;

    wait (table_built);
    limit_ns = (tbl.size() + N_RANDOM + RESET_CYCLES) * 10 * 2;
    #(limit_ns);
    $display("Timeout: tests still running after %0d ns", limit_ns);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* bench/clock_gen.sv */
`timescale 1ns/1ns

module clock_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 4
) (
  output logic clock,
  output logic rst_n
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2) clock = ~clock;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #1 rst_n = 1'b1;  // Released just after the edge
  end

endmodule

/* design/alu_macros.svh */
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Datapath widths
`define ALU_WIDTH   32
`define ALU_DWIDTH  (2 * `ALU_WIDTH)
`define ALU_SHAMT_W 5
`define ALU_OP_W    5

// Opcode encoding as seen by the control unit
`define ALU_OP_ADD  5'b00011
`define ALU_OP_SUB  5'b00100
`define ALU_OP_SHR  5'b00101
`define ALU_OP_SHRA 5'b00110
`define ALU_OP_SHL  5'b00111
`define ALU_OP_ROR  5'b01000
`define ALU_OP_ROL  5'b01001
`define ALU_OP_AND  5'b01010
`define ALU_OP_OR   5'b01011
`define ALU_OP_MUL  5'b01111
`define ALU_OP_DIV  5'b10000
`define ALU_OP_NEG  5'b10001
`define ALU_OP_NOT  5'b10010
`define ALU_OP_NOP  5'b11010

`endif

/* design/alu_pkg.sv */
`include "alu_macros.svh"

package alu_pkg;

  // Operand, or one half of Z
  typedef logic [`ALU_WIDTH-1:0] word_t;

  // Full result, HI above LO
  typedef logic [`ALU_DWIDTH-1:0] dword_t;

  typedef logic [`ALU_OP_W-1:0] opcode_t;

  // Shift and rotate distance, low bits of B
  typedef logic [`ALU_SHAMT_W-1:0] shamt_t;

endpackage

/* design/alu_top.sv */
`timescale 1ns/1ns

module alu_top (
  input  logic             clock,
  input  logic             rst_n,
  input  logic             z_in,
  input  logic             inc_pc,
  input  alu_pkg::opcode_t opcode,
  input  alu_pkg::word_t   a_reg,
  input  alu_pkg::word_t   b_reg,
  output alu_pkg::word_t   z_hi,
  output alu_pkg::word_t   z_lo
);

  import alu_pkg::*;

  dword_t arith_result;
  dword_t logic_result;
  logic   arith_hit;
  logic   logic_hit;

  arith_unit arith_unit_inst (
    .a_reg        (a_reg),
    .b_reg        (b_reg),
    .opcode       (opcode),
    .inc_pc       (inc_pc),
    .arith_result (arith_result),
    .arith_hit    (arith_hit)
  );

  logic_shift_unit logic_shift_unit_inst (
    .a_reg        (a_reg),
    .b_reg        (b_reg),
    .opcode       (opcode),
    .logic_result (logic_result),
    .logic_hit    (logic_hit)
  );

  result_select result_select_inst (
    .clock        (clock),
    .rst_n        (rst_n),
    .z_in         (z_in),
    .opcode       (opcode),
    .arith_result (arith_result),
    .arith_hit    (arith_hit),
    .logic_result (logic_result),
    .logic_hit    (logic_hit),
    .z_hi         (z_hi),
    .z_lo         (z_lo)
  );

endmodule

/* design/arith_unit.sv */
`timescale 1ns/1ns
`include "alu_macros.svh"

module arith_unit (
  input  alu_pkg::word_t   a_reg,
  input  alu_pkg::word_t   b_reg,
  input  alu_pkg::opcode_t opcode,
  input  logic             inc_pc,
  output alu_pkg::dword_t  arith_result,
  output logic             arith_hit
);

  import alu_pkg::*;

  word_t  sum;
  word_t  diff;
  word_t  neg_b;
  word_t  pc_next;
  dword_t product;
  word_t  quotient;
  word_t  remainder;

  assign sum     = a_reg + b_reg;
  assign diff    = a_reg - b_reg;
  assign neg_b   = ~b_reg + 1'b1;  // Two's complement of B
  assign pc_next = a_reg + 1'b1;

  // Radix-4 Booth, one recoded digit per pass
  always_comb begin : booth_mul
    dword_t              mcand;
    dword_t              pp;
    logic [2:0]          booth_bits;
    logic [`ALU_WIDTH:0] mplier;

    mcand   = {{`ALU_WIDTH{a_reg[`ALU_WIDTH-1]}}, a_reg};
    mplier  = {b_reg, 1'b0};  // Implicit zero below bit 0
    product = '0;
    for (int i = 0; i < `ALU_WIDTH / 2; i++) begin
      booth_bits = mplier[2*i +: 3];
      case (booth_bits)
        3'b001, 3'b010: pp = mcand;
        3'b011:         pp = mcand << 1;
        3'b100:         pp = -(mcand << 1);
        3'b101, 3'b110: pp = -mcand;
        default:        pp = '0;
      endcase
      product = product + (pp << (2 * i));
    end
  end

  // Restoring division on magnitudes, signs applied afterwards
  always_comb begin : restoring_div
    logic                a_neg;
    logic                b_neg;
    word_t               a_mag;
    word_t               b_mag;
    word_t               q_mag;
    logic [`ALU_WIDTH:0] part_rem;
    logic [`ALU_WIDTH:0] trial;

    a_neg    = a_reg[`ALU_WIDTH-1];
    b_neg    = b_reg[`ALU_WIDTH-1];
    a_mag    = a_neg ? -a_reg : a_reg;
    b_mag    = b_neg ? -b_reg : b_reg;
    q_mag    = '0;
    part_rem = '0;
    for (int i = `ALU_WIDTH - 1; i >= 0; i--) begin
      part_rem = {part_rem[`ALU_WIDTH-1:0], a_mag[i]};
      trial    = part_rem - {1'b0, b_mag};
      if (!trial[`ALU_WIDTH]) begin  // No borrow, keep difference
        part_rem = trial;
        q_mag[i] = 1'b1;
      end
    end

    if (b_reg == '0) begin
      quotient  = '1;
      remainder = a_reg;
    end else begin
      // Quotient truncates toward zero
      quotient  = (a_neg ^ b_neg) ? -q_mag : q_mag;
      remainder = a_neg ? -part_rem[`ALU_WIDTH-1:0] : part_rem[`ALU_WIDTH-1:0];
    end
  end

  always_comb begin
    arith_result = '0;
    arith_hit    = 1'b1;
    if (inc_pc) begin
      arith_result = dword_t'(pc_next);  // Overrides any opcode
    end else begin
      case (opcode)
        `ALU_OP_ADD: arith_result = dword_t'(sum);
        `ALU_OP_SUB: arith_result = dword_t'(diff);
        `ALU_OP_NEG: arith_result = dword_t'(neg_b);
        `ALU_OP_MUL: arith_result = product;
        `ALU_OP_DIV: arith_result = {remainder, quotient};  // Remainder in HI
        default:     arith_hit    = 1'b0;
      endcase
    end
  end

endmodule

/* design/logic_shift_unit.sv */
`timescale 1ns/1ns
`include "alu_macros.svh"

module logic_shift_unit (
  input  alu_pkg::word_t   a_reg,
  input  alu_pkg::word_t   b_reg,
  input  alu_pkg::opcode_t opcode,
  output alu_pkg::dword_t  logic_result,
  output logic             logic_hit
);

  import alu_pkg::*;

  shamt_t shamt;
  dword_t a_twice;
  dword_t ror_wide;
  dword_t rol_wide;
  word_t  shr_a;
  word_t  shra_a;
  word_t  shl_a;
  word_t  ror_a;
  word_t  rol_a;

  assign shamt = b_reg[`ALU_SHAMT_W-1:0];  // Upper bits of B ignored

  assign shr_a  = a_reg >> shamt;
  assign shra_a = $signed(a_reg) >>> shamt;  // Sign fill
  assign shl_a  = a_reg << shamt;

  // Rotates from a doubled copy of A
  assign a_twice  = {a_reg, a_reg};
  assign ror_wide = a_twice >> shamt;
  assign rol_wide = a_twice << shamt;
  assign ror_a    = ror_wide[`ALU_WIDTH-1:0];
  assign rol_a    = rol_wide[`ALU_DWIDTH-1:`ALU_WIDTH];

  always_comb begin
    word_t low_word;

    low_word  = '0;
    logic_hit = 1'b1;
    case (opcode)
      `ALU_OP_AND:  low_word  = a_reg & b_reg;
      `ALU_OP_OR:   low_word  = a_reg | b_reg;
      `ALU_OP_NOT:  low_word  = ~b_reg;
      `ALU_OP_SHR:  low_word  = shr_a;
      `ALU_OP_SHRA: low_word  = shra_a;
      `ALU_OP_SHL:  low_word  = shl_a;
      `ALU_OP_ROR:  low_word  = ror_a;
      `ALU_OP_ROL:  low_word  = rol_a;
      default:      logic_hit = 1'b0;
    endcase
    logic_result = dword_t'(low_word);
  end

endmodule

/* design/result_select.sv */
`timescale 1ns/1ns
`include "alu_macros.svh"

module result_select (
  input  logic             clock,
  input  logic             rst_n,
  input  logic             z_in,
  input  alu_pkg::opcode_t opcode,
  input  alu_pkg::dword_t  arith_result,
  input  logic             arith_hit,
  input  alu_pkg::dword_t  logic_result,
  input  logic             logic_hit,
  output alu_pkg::word_t   z_hi,
  output alu_pkg::word_t   z_lo
);

  import alu_pkg::*;

  dword_t z_reg;
  dword_t z_next;

  // Arith wins over logic, then nop, then clear
  always_comb begin
    if (arith_hit) begin
      z_next = arith_result;
    end else if (logic_hit) begin
      z_next = logic_result;
    end else if (opcode == `ALU_OP_NOP) begin
      z_next = z_reg;
    end else begin
      z_next = '0;  // Undefined opcode
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      z_reg <= '0;
    end else if (z_in) begin
      z_reg <= z_next;
    end
  end

  assign z_hi = z_reg[`ALU_DWIDTH-1:`ALU_WIDTH];
  assign z_lo = z_reg[`ALU_WIDTH-1:0];

  a_undef_clears_z: assert property (
    @(posedge clock) disable iff (!rst_n)
    z_in && !arith_hit && !logic_hit && opcode != `ALU_OP_NOP |=> z_reg == '0
  ) else $error("result_select: Z not cleared for opcode %b", $past(opcode));

  // Overlap only from inc_pc on a logic opcode
  a_dual_hit_pc: assert property (
    @(posedge clock) disable iff (!rst_n)
    arith_hit && logic_hit |-> arith_result[`ALU_DWIDTH-1:`ALU_WIDTH] == '0
  ) else $error("result_select: both hits with wide arith result");

endmodule
